// ==== hdl/opLoadPkg.sv ====
`default_nettype none

package opLoadPkg;

    // Port counts
    localparam int NUM_UOPS = 2;
    localparam int NUM_WBS = 2;
    localparam int NUM_RD_PORTS = 2 * NUM_UOPS;

    // Storage depths
    localparam int NUM_REGS = 64;
    localparam int NUM_FETCH_IDS = 16;

    // Field widths
    localparam int WORD_W = 32;
    localparam int TAG_W = 7;
    localparam int IDX_W = 6;
    localparam int SQN_W = 7;
    localparam int FETCH_ID_W = 4;
    localparam int FETCH_OFF_W = 3;
    localparam int OPCODE_W = 6;

    typedef logic [WORD_W-1:0] Word_t;

    // Bit 6 set means the low bits are a signed constant, not a register
    typedef logic [TAG_W-1:0] RegTag_t;
    typedef logic [IDX_W-1:0] RegIdx_t;

    typedef logic [SQN_W-1:0] SqN_t;
    typedef logic [FETCH_ID_W-1:0] FetchId_t;

    // Halfword offset within a fetch block
    typedef logic [FETCH_OFF_W-1:0] FetchOff_t;
    typedef logic [OPCODE_W-1:0] Opcode_t;

    // True when a is younger than b under wrapping age compare
    function automatic logic isYounger(SqN_t a, SqN_t b);
        SqN_t diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    // Sign-extended small constant carried in the tag
    function automatic Word_t constFromTag(RegTag_t tag);
        return {{(WORD_W - IDX_W){tag[IDX_W-1]}}, tag[IDX_W-1:0]};
    endfunction

    function automatic logic tagIsConst(RegTag_t tag);
        return tag[TAG_W-1];
    endfunction

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
    import opLoadPkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  RegIdx_t rdIdx [NUM_RD_PORTS],
    output Word_t   rdData [NUM_RD_PORTS],
    input  wire     wbValid [NUM_WBS],
    input  RegTag_t wbTag [NUM_WBS],
    input  Word_t   wbResult [NUM_WBS]
);

    Word_t regs [NUM_REGS];

    // Later slots overwrite earlier ones on the same index
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int j = 0; j < NUM_WBS; j++) begin
                if (wbValid[j] && !tagIsConst(wbTag[j])) begin
                    regs[wbTag[j][IDX_W-1:0]] <= wbResult[j];
                end
            end
        end
    end

    // Read data lands in the cycle after the index is presented
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rdData[p] <= regs[rdIdx[p]];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pcFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcFile
    import opLoadPkg::*;
(
    input  wire       clk,
    input  wire       pcWrite,
    input  FetchId_t  pcWriteId,
    input  Word_t     pcWriteBase,
    input  FetchOff_t pcWriteBranchPos,
    input  wire       pcWritePredicted,
    input  wire       pcWriteTaken,
    input  FetchId_t  rdId [NUM_UOPS],
    output Word_t     rdBase [NUM_UOPS],
    output FetchOff_t rdBranchPos [NUM_UOPS],
    output logic      rdPredicted [NUM_UOPS],
    output logic      rdTaken [NUM_UOPS]
);

    Word_t     baseMem [NUM_FETCH_IDS];
    FetchOff_t branchPosMem [NUM_FETCH_IDS];
    logic      predictedMem [NUM_FETCH_IDS];
    logic      takenMem [NUM_FETCH_IDS];

    always_ff @(posedge clk) begin
        if (pcWrite) begin
            baseMem[pcWriteId] <= pcWriteBase;
            branchPosMem[pcWriteId] <= pcWriteBranchPos;
            predictedMem[pcWriteId] <= pcWritePredicted;
            takenMem[pcWriteId] <= pcWriteTaken;
        end
    end

    // One synchronous read per issue port
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            rdBase[i] <= baseMem[rdId[i]];
            rdBranchPos[i] <= branchPosMem[rdId[i]];
            rdPredicted[i] <= predictedMem[rdId[i]];
            rdTaken[i] <= takenMem[rdId[i]];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/operandSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandSelect
    import opLoadPkg::*;
(
    input  RegTag_t tagA,
    input  RegTag_t tagB,
    input  Word_t   imm,
    input  wire     immB,
    input  wire     wbValid [NUM_WBS],
    input  RegTag_t wbTag [NUM_WBS],
    input  Word_t   wbResult [NUM_WBS],
    output Word_t   valA,
    output Word_t   valB,
    output logic    needsRegA,
    output logic    needsRegB
);

    // Returns {needsReg, value} for one tag
    function automatic logic [WORD_W:0] resolveTag(RegTag_t tag);
        Word_t value;
        logic  needsReg;
        value = '0;
        needsReg = 1'b0;
        if (tagIsConst(tag)) begin
            value = constFromTag(tag);
        end else begin
            needsReg = 1'b1;
            // Scan upward so the higher slot wins on a double match
            for (int j = 0; j < NUM_WBS; j++) begin
                if (wbValid[j] && wbTag[j] == tag) begin
                    value = wbResult[j];
                    needsReg = 1'b0;
                end
            end
        end
        return {needsReg, value};
    endfunction

    logic [WORD_W:0] resA;
    logic [WORD_W:0] resB;

    always_comb begin
        resA = resolveTag(tagA);
        if (immB) begin
            resB = {1'b0, imm};
        end else begin
            resB = resolveTag(tagB);
        end
    end

    assign valA = resA[WORD_W-1:0];
    assign needsRegA = resA[WORD_W];
    assign valB = resB[WORD_W-1:0];
    assign needsRegB = resB[WORD_W];

endmodule

`default_nettype wire

// ==== hdl/uopLatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module uopLatch
    import opLoadPkg::*;
(
    input  wire       clk,
    input  wire       capture,
    input  wire       clear,
    input  wire       absorb,
    input  Word_t     inImm,
    input  SqN_t      inSqN,
    input  RegTag_t   inTagDst,
    input  Opcode_t   inOpcode,
    input  FetchOff_t inFetchOffs,
    input  wire       inCompressed,
    input  Word_t     valA,
    input  Word_t     valB,
    input  Word_t     rdDataA,
    input  Word_t     rdDataB,
    input  Word_t     rdBase,
    input  FetchOff_t rdBranchPos,
    input  wire       rdPredicted,
    input  wire       rdTaken,
    input  wire       pendA,
    input  wire       pendB,
    output Word_t     outSrcA,
    output Word_t     outSrcB,
    output Word_t     outImm,
    output Word_t     outPc,
    output SqN_t      outSqN,
    output RegTag_t   outTagDst,
    output Opcode_t   outOpcode,
    output logic      outPredicted,
    output logic      outTaken,
    output SqN_t      heldSqN
);

    Word_t     srcA;
    Word_t     srcB;
    SqN_t      sqN;
    FetchOff_t fetchOffs;
    logic      compressed;
    Word_t     pcReg;
    logic      predReg;
    logic      takenReg;

    // High in the cycle the PC-file data belongs to the held micro-op
    logic      pcPend;

    Word_t     pcNew;
    logic      branchHere;

    assign pcNew = {rdBase[WORD_W-1:FETCH_OFF_W+1], fetchOffs, 1'b0}
                   - (compressed ? Word_t'(0) : Word_t'(2));
    assign branchHere = (fetchOffs == rdBranchPos);

    always_ff @(posedge clk) begin
        pcPend <= capture;
        if (capture) begin
            srcA <= valA;
            srcB <= valB;
            outImm <= inImm;
            sqN <= inSqN;
            outTagDst <= inTagDst;
            outOpcode <= inOpcode;
            fetchOffs <= inFetchOffs;
            compressed <= inCompressed;
        end else if (absorb) begin
            if (pendA) srcA <= rdDataA;
            if (pendB) srcB <= rdDataB;
        end
        // First stall cycle after capture
        if (pcPend && !capture && !clear) begin
            pcReg <= pcNew;
            predReg <= rdPredicted && branchHere;
            takenReg <= rdTaken && branchHere;
        end
    end

    assign outSrcA = pendA ? rdDataA : srcA;
    assign outSrcB = pendB ? rdDataB : srcB;
    assign outPc = pcPend ? pcNew : pcReg;
    assign outPredicted = pcPend ? (rdPredicted && branchHere) : predReg;
    assign outTaken = pcPend ? (rdTaken && branchHere) : takenReg;
    assign outSqN = sqN;
    assign heldSqN = sqN;

endmodule

`default_nettype wire

// ==== hdl/loadControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadControl
    import opLoadPkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  inValid [NUM_UOPS],
    input  wire  stall [NUM_UOPS],
    input  wire  invalidate,
    input  SqN_t invalidateSqN,
    input  SqN_t inSqN [NUM_UOPS],
    input  SqN_t heldSqN [NUM_UOPS],
    input  wire  needsRegA [NUM_UOPS],
    input  wire  needsRegB [NUM_UOPS],
    output logic capture [NUM_UOPS],
    output logic clear [NUM_UOPS],
    output logic absorb [NUM_UOPS],
    output logic pendA [NUM_UOPS],
    output logic pendB [NUM_UOPS],
    output logic outValid [NUM_UOPS]
);

    logic kill [NUM_UOPS];

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            capture[i] = !stall[i] && inValid[i]
                         && !(invalidate && isYounger(inSqN[i], invalidateSqN));
            // Held micro-op is squashed even while stalled
            kill[i] = outValid[i] && invalidate && isYounger(heldSqN[i], invalidateSqN);
            clear[i] = !capture[i] && (!stall[i] || kill[i]);
            absorb[i] = stall[i] && outValid[i] && !kill[i] && (pendA[i] || pendB[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (rst) begin
                outValid[i] <= 1'b0;
                pendA[i] <= 1'b0;
                pendB[i] <= 1'b0;
            end else if (capture[i]) begin
                outValid[i] <= 1'b1;
                pendA[i] <= needsRegA[i];
                pendB[i] <= needsRegB[i];
            end else if (clear[i]) begin
                outValid[i] <= 1'b0;
                pendA[i] <= 1'b0;
                pendB[i] <= 1'b0;
            end else if (absorb[i]) begin
                pendA[i] <= 1'b0;
                pendB[i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/operandLoad.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandLoad
    import opLoadPkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       inValid [NUM_UOPS],
    input  RegTag_t   inTagA [NUM_UOPS],
    input  RegTag_t   inTagB [NUM_UOPS],
    input  RegTag_t   inTagDst [NUM_UOPS],
    input  Word_t     inImm [NUM_UOPS],
    input  wire       inImmB [NUM_UOPS],
    input  SqN_t      inSqN [NUM_UOPS],
    input  Opcode_t   inOpcode [NUM_UOPS],
    input  FetchId_t  inFetchId [NUM_UOPS],
    input  FetchOff_t inFetchOffs [NUM_UOPS],
    input  wire       inCompressed [NUM_UOPS],
    input  wire       stall [NUM_UOPS],
    input  wire       invalidate,
    input  SqN_t      invalidateSqN,
    input  wire       wbValid [NUM_WBS],
    input  RegTag_t   wbTag [NUM_WBS],
    input  Word_t     wbResult [NUM_WBS],
    input  wire       pcWrite,
    input  FetchId_t  pcWriteId,
    input  Word_t     pcWriteBase,
    input  FetchOff_t pcWriteBranchPos,
    input  wire       pcWritePredicted,
    input  wire       pcWriteTaken,
    output logic      outValid [NUM_UOPS],
    output Word_t     outSrcA [NUM_UOPS],
    output Word_t     outSrcB [NUM_UOPS],
    output Word_t     outImm [NUM_UOPS],
    output Word_t     outPc [NUM_UOPS],
    output SqN_t      outSqN [NUM_UOPS],
    output RegTag_t   outTagDst [NUM_UOPS],
    output Opcode_t   outOpcode [NUM_UOPS],
    output logic      outPredicted [NUM_UOPS],
    output logic      outTaken [NUM_UOPS]
);

    RegIdx_t   rdIdx [NUM_RD_PORTS];
    Word_t     rdData [NUM_RD_PORTS];
    Word_t     rdBase [NUM_UOPS];
    FetchOff_t rdBranchPos [NUM_UOPS];
    logic      rdPredicted [NUM_UOPS];
    logic      rdTaken [NUM_UOPS];

    Word_t valA [NUM_UOPS];
    Word_t valB [NUM_UOPS];
    logic  needsRegA [NUM_UOPS];
    logic  needsRegB [NUM_UOPS];
    logic  capture [NUM_UOPS];
    logic  clear [NUM_UOPS];
    logic  absorb [NUM_UOPS];
    logic  pendA [NUM_UOPS];
    logic  pendB [NUM_UOPS];
    SqN_t  heldSqN [NUM_UOPS];

    // Operand A reads use the low ports, operand B the high ones
    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            rdIdx[i] = inTagA[i][IDX_W-1:0];
            rdIdx[i + NUM_UOPS] = inTagB[i][IDX_W-1:0];
        end
    end

    regFile regs (
        .clk(clk), .rst(rst), .rdIdx(rdIdx), .rdData(rdData),
        .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult)
    );

    pcFile pcs (
        .clk(clk), .pcWrite(pcWrite), .pcWriteId(pcWriteId), .pcWriteBase(pcWriteBase),
        .pcWriteBranchPos(pcWriteBranchPos), .pcWritePredicted(pcWritePredicted),
        .pcWriteTaken(pcWriteTaken), .rdId(inFetchId), .rdBase(rdBase),
        .rdBranchPos(rdBranchPos), .rdPredicted(rdPredicted), .rdTaken(rdTaken)
    );

    loadControl ctrl (
        .clk(clk), .rst(rst), .inValid(inValid), .stall(stall), .invalidate(invalidate),
        .invalidateSqN(invalidateSqN), .inSqN(inSqN), .heldSqN(heldSqN),
        .needsRegA(needsRegA), .needsRegB(needsRegB), .capture(capture), .clear(clear),
        .absorb(absorb), .pendA(pendA), .pendB(pendB), .outValid(outValid)
    );

    for (genvar g = 0; g < NUM_UOPS; g++) begin : gPort
        operandSelect sel (
            .tagA(inTagA[g]), .tagB(inTagB[g]), .imm(inImm[g]), .immB(inImmB[g]),
            .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult),
            .valA(valA[g]), .valB(valB[g]),
            .needsRegA(needsRegA[g]), .needsRegB(needsRegB[g])
        );

        uopLatch latch (
            .clk(clk), .capture(capture[g]), .clear(clear[g]), .absorb(absorb[g]),
            .inImm(inImm[g]), .inSqN(inSqN[g]), .inTagDst(inTagDst[g]),
            .inOpcode(inOpcode[g]), .inFetchOffs(inFetchOffs[g]),
            .inCompressed(inCompressed[g]), .valA(valA[g]), .valB(valB[g]),
            .rdDataA(rdData[g]), .rdDataB(rdData[g + NUM_UOPS]), .rdBase(rdBase[g]),
            .rdBranchPos(rdBranchPos[g]), .rdPredicted(rdPredicted[g]),
            .rdTaken(rdTaken[g]), .pendA(pendA[g]), .pendB(pendB[g]),
            .outSrcA(outSrcA[g]), .outSrcB(outSrcB[g]), .outImm(outImm[g]),
            .outPc(outPc[g]), .outSqN(outSqN[g]), .outTagDst(outTagDst[g]),
            .outOpcode(outOpcode[g]), .outPredicted(outPredicted[g]),
            .outTaken(outTaken[g]), .heldSqN(heldSqN[g])
        );
    end

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset covers the first 8 rising edges and drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tbOperandLoad.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbOperandLoad
    import opLoadPkg::*;
();

    typedef struct packed {
        Word_t   srcA;
        Word_t   srcB;
        Word_t   imm;
        Word_t   pc;
        SqN_t    sqN;
        RegTag_t tagDst;
        Opcode_t opcode;
        logic    predicted;
        logic    taken;
    } UopRec_t;

    logic      clk;
    logic      rst;
    logic      inValid [NUM_UOPS], inImmB [NUM_UOPS], inCompressed [NUM_UOPS], stall [NUM_UOPS];
    RegTag_t   inTagA [NUM_UOPS], inTagB [NUM_UOPS], inTagDst [NUM_UOPS];
    Word_t     inImm [NUM_UOPS];
    SqN_t      inSqN [NUM_UOPS];
    Opcode_t   inOpcode [NUM_UOPS];
    FetchId_t  inFetchId [NUM_UOPS];
    FetchOff_t inFetchOffs [NUM_UOPS];
    logic      invalidate;
    SqN_t      invalidateSqN;
    logic      wbValid [NUM_WBS];
    RegTag_t   wbTag [NUM_WBS];
    Word_t     wbResult [NUM_WBS];
    logic      pcWrite, pcWritePredicted, pcWriteTaken;
    FetchId_t  pcWriteId;
    Word_t     pcWriteBase;
    FetchOff_t pcWriteBranchPos;
    logic      outValid [NUM_UOPS], outPredicted [NUM_UOPS], outTaken [NUM_UOPS];
    Word_t     outSrcA [NUM_UOPS], outSrcB [NUM_UOPS], outImm [NUM_UOPS], outPc [NUM_UOPS];
    SqN_t      outSqN [NUM_UOPS];
    RegTag_t   outTagDst [NUM_UOPS];
    Opcode_t   outOpcode [NUM_UOPS];

    // Shadow copies of the register file and fetch-PC table
    Word_t     shadowRegs [NUM_REGS];
    Word_t     shadowBase [NUM_FETCH_IDS];
    FetchOff_t shadowBranchPos [NUM_FETCH_IDS];
    logic      shadowPredicted [NUM_FETCH_IDS], shadowTaken [NUM_FETCH_IDS];
    logic      expValid [NUM_UOPS];
    UopRec_t   expRec [NUM_UOPS];
    logic      modelReady = 1'b0;
    integer    seed;
    int        checkCount = 0;
    int        errorCount = 0;
    int        timeoutCount = 0;

    tbClock clockGen (.clk(clk), .rst(rst));

    operandLoad u_dut (.*);

    // Signed wrapping distance above zero
    function automatic logic sqNYounger(SqN_t a, SqN_t b);
        SqN_t diff;
        diff = a - b;
        return !diff[SQN_W-1] && (diff != '0);
    endfunction

    function automatic Word_t operandValue(RegTag_t tag);
        Word_t value;
        value = shadowRegs[tag[IDX_W-1:0]];
        if (tag[TAG_W-1]) begin
            // Six-bit two's complement value
            value = Word_t'(int'(tag[IDX_W-1:0]) - (tag[IDX_W-1] ? (1 << IDX_W) : 0));
        end else begin
            for (int j = 0; j < NUM_WBS; j++) begin
                if (wbValid[j] && wbTag[j] == tag) begin
                    value = wbResult[j];
                end
            end
        end
        return value;
    endfunction

    function automatic UopRec_t expectedUop(int p);
        UopRec_t rec;
        Word_t   base;
        logic    atBranch;
        base = shadowBase[inFetchId[p]];
        atBranch = inFetchOffs[p] == shadowBranchPos[inFetchId[p]];
        rec.srcA = operandValue(inTagA[p]);
        rec.srcB = inImmB[p] ? inImm[p] : operandValue(inTagB[p]);
        rec.imm = inImm[p];
        rec.pc = {base[31:4], inFetchOffs[p], 1'b0} - (inCompressed[p] ? 32'd0 : 32'd2);
        rec.sqN = inSqN[p];
        rec.tagDst = inTagDst[p];
        rec.opcode = inOpcode[p];
        rec.predicted = shadowPredicted[inFetchId[p]] && atBranch;
        rec.taken = shadowTaken[inFetchId[p]] && atBranch;
        return rec;
    endfunction

    // Reference model steps on the rising edge, after reads and before writes
    always @(posedge clk) begin
        for (int p = 0; p < NUM_UOPS; p++) begin
            if (rst) begin
                expValid[p] = 1'b0;
            end else if (!stall[p] && inValid[p]
                         && !(invalidate && sqNYounger(inSqN[p], invalidateSqN))) begin
                expValid[p] = 1'b1;
                expRec[p] = expectedUop(p);
            end else if (!stall[p]
                         || (invalidate && sqNYounger(expRec[p].sqN, invalidateSqN))) begin
                expValid[p] = 1'b0;
            end
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            if (rst) begin
                shadowRegs[r] = '0;
            end
        end
        for (int j = 0; j < NUM_WBS; j++) begin
            if (!rst && wbValid[j] && !wbTag[j][TAG_W-1]) begin
                shadowRegs[wbTag[j][IDX_W-1:0]] = wbResult[j];
            end
        end
        if (pcWrite) begin
            shadowBase[pcWriteId] = pcWriteBase;
            shadowBranchPos[pcWriteId] = pcWriteBranchPos;
            shadowPredicted[pcWriteId] = pcWritePredicted;
            shadowTaken[pcWriteId] = pcWriteTaken;
        end
        modelReady = 1'b1;
    end

    task automatic compareValue(string name, int port, logic [31:0] got, logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t: %s[%0d] is %h, expected %h", $time, name, port, got, exp);
        end
    endtask

    // Outputs only change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (modelReady) begin
            for (int p = 0; p < NUM_UOPS; p++) begin
                compareValue("outValid", p, 32'(outValid[p]), 32'(expValid[p]));
                if (expValid[p]) begin
                    compareValue("outSrcA", p, outSrcA[p], expRec[p].srcA);
                    compareValue("outSrcB", p, outSrcB[p], expRec[p].srcB);
                    compareValue("outImm", p, outImm[p], expRec[p].imm);
                    compareValue("outPc", p, outPc[p], expRec[p].pc);
                    compareValue("outSqN", p, 32'(outSqN[p]), 32'(expRec[p].sqN));
                    compareValue("outTagDst", p, 32'(outTagDst[p]), 32'(expRec[p].tagDst));
                    compareValue("outOpcode", p, 32'(outOpcode[p]), 32'(expRec[p].opcode));
                    compareValue("outPredicted", p, 32'(outPredicted[p]),
                                 32'(expRec[p].predicted));
                    compareValue("outTaken", p, 32'(outTaken[p]), 32'(expRec[p].taken));
                end
            end
        end
    end

    function automatic RegTag_t randomTag();
        if (($random(seed) & 3) == 0) begin
            return {1'b1, RegIdx_t'($random(seed))};
        end
        // Few registers so forwards and double matches come up often
        return {4'b0000, 3'($random(seed))};
    endfunction

    task automatic driveRandomCycle();
        for (int p = 0; p < NUM_UOPS; p++) begin
            inValid[p] = ($random(seed) & 3) != 0;
            inTagA[p] = randomTag();
            inTagB[p] = randomTag();
            inTagDst[p] = RegTag_t'($random(seed));
            inImm[p] = $random(seed);
            inImmB[p] = ($random(seed) & 3) == 0;
            inSqN[p] = SqN_t'($random(seed));
            inOpcode[p] = Opcode_t'($random(seed));
            inFetchId[p] = FetchId_t'($random(seed));
            inFetchOffs[p] = FetchOff_t'($random(seed));
            inCompressed[p] = 1'($random(seed));
            stall[p] = ($random(seed) & 3) == 0;
        end
        invalidate = ($random(seed) & 7) == 0;
        invalidateSqN = SqN_t'($random(seed));
        for (int j = 0; j < NUM_WBS; j++) begin
            wbValid[j] = 1'($random(seed));
            wbTag[j] = randomTag();
            wbResult[j] = $random(seed);
        end
        pcWrite = ($random(seed) & 7) == 0;
        pcWriteId = FetchId_t'($random(seed));
        pcWriteBase = $random(seed);
        pcWriteBranchPos = FetchOff_t'($random(seed));
        pcWritePredicted = 1'($random(seed));
        pcWriteTaken = 1'($random(seed));
    endtask

    task automatic setIdle();
        for (int p = 0; p < NUM_UOPS; p++) begin
            inValid[p] = 1'b0;
            stall[p] = 1'b0;
        end
        for (int j = 0; j < NUM_WBS; j++) begin
            wbValid[j] = 1'b0;
        end
        invalidate = 1'b0;
        pcWrite = 1'b0;
    endtask

    task automatic waitForReset(int limit);
        int n;
        n = 0;
        while (rst !== 1'b0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            timeoutCount++;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic waitForValid(int p, int limit);
        int n;
        n = 0;
        while (outValid[p] !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (outValid[p] !== 1'b1) begin
            timeoutCount++;
            $display("Timeout: port %0d never showed a valid micro-op", p);
        end
    endtask

    // Both writeback slots hit the operand register in the accept cycle
    task automatic forwardCase();
        @(negedge clk);
        inValid[0] = 1'b1;
        inTagA[0] = 7'd5;
        inTagB[0] = 7'd5;
        inImmB[0] = 1'b0;
        for (int j = 0; j < NUM_WBS; j++) begin
            wbValid[j] = 1'b1;
            wbTag[j] = 7'd5;
            wbResult[j] = 32'h1000_0000 + j;
        end
        @(negedge clk);
        setIdle();
        waitForValid(0, 4);
    endtask

    // Held register operand while the same register is rewritten
    task automatic stallCase();
        @(negedge clk);
        inValid[1] = 1'b1;
        inTagA[1] = 7'd3;
        inImmB[1] = 1'b1;
        @(negedge clk);
        setIdle();
        stall[1] = 1'b1;
        wbValid[0] = 1'b1;
        wbTag[0] = 7'd3;
        wbResult[0] = 32'h5A5A_0003;
        waitForValid(1, 4);
        @(negedge clk);
        wbValid[0] = 1'b0;
        repeat (4) @(negedge clk);
        setIdle();
    endtask

    initial begin
        seed = 50;
        driveRandomCycle();
        setIdle();
        waitForReset(20);
        // Every PC-file entry gets a defined value before any micro-op reads it
        for (int f = 0; f < NUM_FETCH_IDS; f++) begin
            @(negedge clk);
            pcWrite = 1'b1;
            pcWriteId = FetchId_t'(f);
            pcWriteBase = $random(seed);
            pcWriteBranchPos = FetchOff_t'($random(seed));
            pcWritePredicted = 1'($random(seed));
            pcWriteTaken = 1'($random(seed));
        end
        @(negedge clk);
        setIdle();
        forwardCase();
        stallCase();
        for (int c = 0; c < 3000; c++) begin
            @(negedge clk);
            driveRandomCycle();
        end
        @(negedge clk);
        setIdle();
        repeat (3) @(negedge clk);
        // Let the last falling-edge compare finish first
        @(posedge clk);
        $display("%0d checks, %0d mismatches, %0d timeouts", checkCount, errorCount,
                 timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/opLoadPkg.sv
hdl/regFile.sv
hdl/pcFile.sv
hdl/operandSelect.sv
hdl/uopLatch.sv
hdl/loadControl.sv
hdl/operandLoad.sv
testbench/tbClock.sv
testbench/tbOperandLoad.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the operand-load testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=build/sim.log
mkdir -p build &&
    verilator --binary --timing --top-module tbOperandLoad -Mdir build/obj -f compile.f &&
    build/obj/VtbOperandLoad > "$LOG" 2>&1 ||
    { cat "$LOG" 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat "$LOG"
grep -qx "ALL CHECKS PASSED" "$LOG" && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
